// File: hdl/convCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module convCtrl (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  logic               rdValid,
    input  logic               lastElem,
    input  logic               lastWindow,
    input  convPkg::addrT      rdAddr,
    input  logic               resultPending,
    input  logic               wrDone,
    output logic               finish,
    output convPkg::rdReqT     rdReq,
    output convPkg::fetchSelT  fetchSel,
    output logic               stepElem,
    output logic               stepWindow,
    output logic               launch
);

    convPkg::ctrlStateT state;
    convPkg::ctrlStateT stateNext;
    logic outstanding;   // a read is in flight
    logic fetching;

    assign fetching = (state == convPkg::FetchWeight) || (state == convPkg::FetchPixel);
    assign fetchSel = (state == convPkg::FetchWeight) ? convPkg::WeightSel : convPkg::PixelSel;

    assign rdReq.valid = fetching && !outstanding;   // next read right after rdValid
    assign rdReq.addr = rdAddr;

    assign stepElem = fetching && rdValid;
    assign launch = (state == convPkg::Launch) && !resultPending;   // previous result must be out
    assign stepWindow = launch;
    assign finish = (state == convPkg::Done);

    always_comb
    begin
        stateNext = state;
        case (state)
            convPkg::Idle:
            begin
                if (start)
                    stateNext = convPkg::FetchWeight;
            end
            convPkg::FetchWeight:
            begin
                if (rdValid && lastElem)
                    stateNext = convPkg::FetchPixel;   // weights are kept for the run
            end
            convPkg::FetchPixel:
            begin
                if (rdValid && lastElem)
                    stateNext = convPkg::Launch;
            end
            convPkg::Launch:
            begin
                if (launch)
                    stateNext = lastWindow ? convPkg::Drain : convPkg::FetchPixel;
            end
            convPkg::Drain:
            begin
                if (wrDone)
                    stateNext = convPkg::Done;   // only the last result is left
            end
            convPkg::Done:
            begin
                stateNext = convPkg::Done;
            end
            default:
            begin
                stateNext = convPkg::Idle;
            end
        endcase
        if (!start)
            stateNext = convPkg::Idle;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= convPkg::Idle;
            outstanding <= 1'b0;
        end
        else
        begin
            state <= stateNext;
            if (rdReq.valid)
                outstanding <= 1'b1;
            else if (rdValid)
                outstanding <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/convLayer.sv
`timescale 1ns/1ps
`default_nettype none

module convLayer (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    output logic            finish,
    output convPkg::rdReqT  rdReq,
    input  logic            rdValid,
    input  convPkg::pixelT  rdData,
    output convPkg::wrReqT  wrReq,
    input  logic            wrReady
);

    convPkg::fetchSelT fetchSel;
    convPkg::addrT rdAddr;
    convPkg::addrT wrAddr;
    logic [convPkg::ElemW-1:0] elemIdx;
    logic stepElem;
    logic stepWindow;
    logic lastElem;
    logic lastWindow;
    logic launch;
    logic resultPending;
    logic wrDone;
    convPkg::windowT weights;
    convPkg::windowT pixels;

    convCtrl ctrl (
        .clk(clk), .rstN(rstN), .start(start), .rdValid(rdValid),
        .lastElem(lastElem), .lastWindow(lastWindow), .rdAddr(rdAddr),
        .resultPending(resultPending), .wrDone(wrDone), .finish(finish),
        .rdReq(rdReq), .fetchSel(fetchSel), .stepElem(stepElem),
        .stepWindow(stepWindow), .launch(launch)
    );

    windowAddrGen addrGen (
        .clk(clk), .rstN(rstN), .start(start), .fetchSel(fetchSel),
        .stepElem(stepElem), .stepWindow(stepWindow), .rdAddr(rdAddr),
        .elemIdx(elemIdx), .wrAddr(wrAddr), .lastElem(lastElem),
        .lastWindow(lastWindow)
    );

    windowBuffer winBuf (
        .clk(clk), .rstN(rstN), .rdValid(rdValid), .rdData(rdData),
        .fetchSel(fetchSel), .elemIdx(elemIdx), .weights(weights),
        .pixels(pixels)
    );

    macUnit mac (
        .clk(clk), .rstN(rstN), .launch(launch), .weights(weights),
        .pixels(pixels), .wrAddr(wrAddr), .wrReady(wrReady), .wrReq(wrReq),
        .resultPending(resultPending), .wrDone(wrDone)
    );

endmodule

`default_nettype wire

// File: hdl/convPkg.sv
`default_nettype none

package convPkg;

    localparam int ImgWidth = 8;
    localparam int OutWidth = ImgWidth - 2;
    localparam int WinSize = 9;
    localparam int AddrW = 16;
    localparam int ElemW = $clog2(WinSize);   // element index width
    localparam int PosW = $clog2(ImgWidth);   // window row and column width

    // net fixed-point scale of pixel times weight
    localparam int ProdShift = 7;
    localparam int OutMax = 127;

    typedef logic signed [7:0] pixelT;
    typedef logic [AddrW-1:0] addrT;
    typedef pixelT [WinSize-1:0] windowT;   // element k is row k/3, col k%3

    localparam addrT WeightBase = 16'h0000;
    localparam addrT ImageBase = 16'h0100;
    localparam addrT OutBase = 16'h0200;

    typedef struct packed {
        logic valid;   // one-cycle strobe
        addrT addr;
    } rdReqT;

    typedef struct packed {
        logic valid;
        addrT addr;
        pixelT data;
    } wrReqT;

    typedef enum logic [2:0] {Idle, FetchWeight, FetchPixel, Launch, Drain, Done} ctrlStateT;

    typedef enum logic {WeightSel, PixelSel} fetchSelT;

endpackage

`default_nettype wire

// File: hdl/macUnit.sv
`timescale 1ns/1ps
`default_nettype none

module macUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             launch,
    input  convPkg::windowT  weights,
    input  convPkg::windowT  pixels,
    input  convPkg::addrT    wrAddr,
    input  logic             wrReady,
    output convPkg::wrReqT   wrReq,
    output logic             resultPending,
    output logic             wrDone
);

    logic signed [15:0] termQ [convPkg::WinSize];
    logic s1Valid;
    convPkg::addrT s1Addr;
    logic holdValid;
    convPkg::addrT holdAddr;
    convPkg::pixelT holdData;
    logic signed [15:0] sum;
    convPkg::pixelT clamped;

    // magnitudes multiplied, scaled down, then sign restored
    function automatic logic signed [15:0] termOf(input convPkg::pixelT p, input convPkg::pixelT w);
        logic [7:0] magP;
        logic [7:0] magW;
        logic [15:0] prod;
        magP = p[7] ? 8'(-p) : 8'(p);   // -128 gives 128
        magW = w[7] ? 8'(-w) : 8'(w);
        prod = (16'(magP) * 16'(magW)) >> convPkg::ProdShift;
        return (p[7] ^ w[7]) ? -$signed(prod) : $signed(prod);
    endfunction

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            for (int k = 0; k < convPkg::WinSize; k++)
                termQ[k] <= termOf(pixels[k], weights[k]);
            s1Addr <= wrAddr;
        end
        if (s1Valid)
        begin
            holdAddr <= s1Addr;
            holdData <= clamped;
        end
    end

    always_comb
    begin
        sum = '0;
        for (int k = 0; k < convPkg::WinSize; k++)
            sum = sum + termQ[k];
        if (sum < 0)
            clamped = '0;   // relu
        else if (sum > convPkg::OutMax)
            clamped = convPkg::pixelT'(convPkg::OutMax);
        else
            clamped = sum[7:0];
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            s1Valid <= 1'b0;
            holdValid <= 1'b0;
        end
        else
        begin
            s1Valid <= launch;
            if (s1Valid)
                holdValid <= 1'b1;
            else if (wrReq.valid)
                holdValid <= 1'b0;
        end
    end

    assign wrReq = '{valid: holdValid && wrReady, addr: holdAddr, data: holdData};
    assign wrDone = wrReq.valid;
    assign resultPending = s1Valid || holdValid;

endmodule

`default_nettype wire

// File: hdl/windowAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module windowAddrGen (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       start,
    input  convPkg::fetchSelT          fetchSel,
    input  logic                       stepElem,
    input  logic                       stepWindow,
    output convPkg::addrT              rdAddr,
    output logic [convPkg::ElemW-1:0]  elemIdx,
    output convPkg::addrT              wrAddr,
    output logic                       lastElem,
    output logic                       lastWindow
);

    logic [convPkg::PosW-1:0] row;   // top-left corner of the window
    logic [convPkg::PosW-1:0] col;
    logic [convPkg::ElemW-1:0] kRow;   // position inside the window
    logic [convPkg::ElemW-1:0] kCol;
    logic lastCol;

    assign kRow = convPkg::ElemW'(elemIdx / 3);
    assign kCol = convPkg::ElemW'(elemIdx % 3);
    assign lastElem = (elemIdx == convPkg::ElemW'(convPkg::WinSize - 1));
    assign lastCol = (col == convPkg::PosW'(convPkg::OutWidth - 1));
    assign lastWindow = lastCol && (row == convPkg::PosW'(convPkg::OutWidth - 1));

    always_ff @(posedge clk)
    begin
        if (!rstN || !start)
        begin
            elemIdx <= '0;
            row <= '0;
            col <= '0;
        end
        else
        begin
            if (stepElem)
                elemIdx <= lastElem ? '0 : elemIdx + 1'b1;
            if (stepWindow)
            begin
                if (lastCol)
                begin
                    col <= '0;
                    row <= lastWindow ? '0 : row + 1'b1;
                end
                else
                    col <= col + 1'b1;
            end
        end
    end

    always_comb
    begin
        if (fetchSel == convPkg::WeightSel)
            rdAddr = convPkg::WeightBase + convPkg::addrT'(elemIdx);
        else
            rdAddr = convPkg::ImageBase
                   + convPkg::addrT'((row + kRow) * convPkg::ImgWidth)
                   + convPkg::addrT'(col + kCol);
    end

    assign wrAddr = convPkg::OutBase
                  + convPkg::addrT'(row * convPkg::OutWidth)
                  + convPkg::addrT'(col);

endmodule

`default_nettype wire

// File: hdl/windowBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module windowBuffer (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       rdValid,
    input  convPkg::pixelT             rdData,
    input  convPkg::fetchSelT          fetchSel,
    input  logic [convPkg::ElemW-1:0]  elemIdx,
    output convPkg::windowT            weights,
    output convPkg::windowT            pixels
);

    logic weightWe;
    logic pixelWe;

    assign weightWe = rdValid && (fetchSel == convPkg::WeightSel);
    assign pixelWe = rdValid && (fetchSel == convPkg::PixelSel);

    // weights are loaded once per run
    always_ff @(posedge clk)
    begin
        if (!rstN)
            weights <= '0;
        else if (weightWe)
            weights[elemIdx] <= rdData;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            pixels <= '0;
        else if (pixelWe)
            pixels[elemIdx] <= rdData;   // overwritten by the next window
    end

endmodule

`default_nettype wire

// File: test/convLayerTb.sv
`timescale 1ns/1ps
`default_nettype none

module convLayerTb;

    localparam int NumOut = convPkg::OutWidth * convPkg::OutWidth;
    localparam int ReadTotal = convPkg::WinSize * (NumOut + 1);   // weights plus every window
    localparam int MemWords = 1024;
    localparam int RunLimit = 20000;

    logic clk;
    logic rstN;
    logic start;
    logic finish;
    logic rdValid;
    logic wrReady;
    convPkg::pixelT rdData;
    convPkg::rdReqT rdReq;
    convPkg::wrReqT wrReq;

    convPkg::pixelT mem [MemWords];
    convPkg::pixelT expected [NumOut];
    int readCount = 0;
    int writeCount = 0;
    bit readPending = 1'b0;
    int readDelay = 0;
    convPkg::addrT readAddr = '0;

    convLayer DUT (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .finish(finish),
        .rdReq(rdReq),
        .rdValid(rdValid),
        .rdData(rdData),
        .wrReq(wrReq),
        .wrReady(wrReady)
    );

    always #10 clk = ~clk;

    task automatic checkEq(input string name, input logic [31:0] actual,
                           input logic [31:0] want);
        if (actual !== want)
        begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, want);
            $display("Testbench failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped on timeout");
    endtask

    // nine weights first, then each window in row-major order
    function automatic int expectedReadAddr(input int idx);
        int win;
        int k;
        if (idx < convPkg::WinSize)
            return convPkg::WeightBase + idx;
        win = (idx - convPkg::WinSize) / convPkg::WinSize;
        k = (idx - convPkg::WinSize) % convPkg::WinSize;
        return convPkg::ImageBase + (win / convPkg::OutWidth + k / 3) * convPkg::ImgWidth
               + win % convPkg::OutWidth + k % 3;
    endfunction

    function automatic convPkg::pixelT refPixel(input int r, input int c);
        int sum;
        int p;
        int w;
        int term;
        sum = 0;
        for (int k = 0; k < convPkg::WinSize; k++)
        begin
            p = mem[convPkg::ImageBase + (r + k / 3) * convPkg::ImgWidth + c + k % 3];
            w = mem[convPkg::WeightBase + k];
            term = ((p < 0 ? -p : p) * (w < 0 ? -w : w)) / (1 << convPkg::ProdShift);
            if ((p < 0) != (w < 0))
                term = -term;   // truncates toward zero
            sum += term;
        end
        if (sum < 0)
            return 8'sd0;
        if (sum > convPkg::OutMax)
            return convPkg::pixelT'(convPkg::OutMax);
        return convPkg::pixelT'(sum);
    endfunction

    // memory model answering each read after 1 to 4 cycles
    always @(posedge clk)
    begin
        rdValid <= 1'b0;
        if (rdReq.valid)
        begin
            checkEq("read count in range", readCount < ReadTotal, 1);
            checkEq("rdReq.addr", rdReq.addr, expectedReadAddr(readCount));
            readCount++;
            readPending = 1'b1;
            readDelay = $urandom_range(3, 0);
            readAddr = rdReq.addr;
        end
        if (readPending)
        begin
            if (readDelay == 0)
            begin
                rdValid <= 1'b1;
                rdData <= mem[readAddr[9:0]];
                readPending = 1'b0;
            end
            else
                readDelay--;
        end
    end

    always @(posedge clk)
    begin
        wrReady <= ($urandom_range(9, 0) < 7);   // about 70 percent ready
        if (wrReq.valid)
        begin
            checkEq("write count in range", writeCount < NumOut, 1);
            checkEq("wrReq.addr", wrReq.addr, convPkg::OutBase + writeCount);
            checkEq("wrReq.data", wrReq.data, expected[writeCount]);
            writeCount++;
        end
    end

    task automatic runOnce();
        int cycles;
        for (int a = 0; a < MemWords; a++)
            mem[a] = convPkg::pixelT'($urandom);
        for (int r = 0; r < convPkg::OutWidth; r++)
            for (int c = 0; c < convPkg::OutWidth; c++)
                expected[r * convPkg::OutWidth + c] = refPixel(r, c);
        readCount = 0;
        writeCount = 0;
        @(posedge clk);
        start <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (writeCount < NumOut)
        begin
            checkEq("finish", finish, 0);
            @(negedge clk);
            cycles++;
            if (cycles > RunLimit)
                timeoutFail("timed out waiting for all output writes");
        end
        checkEq("finish", finish, 1);   // rises right after the last write
        checkEq("total reads", readCount, ReadTotal);
        for (int i = 0; i < 12; i++)
        begin
            @(negedge clk);
            checkEq("finish", finish, 1);
            checkEq("rdReq.valid", rdReq.valid, 0);
            checkEq("wrReq.valid", wrReq.valid, 0);
        end
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (finish)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 5)
                timeoutFail("finish did not fall after start was dropped");
        end
    endtask

    initial
    begin
        void'($urandom(16));
        clk = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        rdValid = 1'b0;
        rdData = '0;
        wrReady = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            @(negedge clk);
            checkEq("rdReq.valid", rdReq.valid, 0);
            checkEq("wrReq.valid", wrReq.valid, 0);
            checkEq("finish", finish, 0);
        end
        runOnce();
        runOnce();   // fresh memory contents
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/convLayer_props.sv
`timescale 1ns/1ps
`default_nettype none

module convLayerProps (
    input logic            clk,
    input logic            rstN,
    input logic            start,
    input logic            finish,
    input logic            rdValid,
    input logic            wrReady,
    input convPkg::rdReqT  rdReq,
    input convPkg::wrReqT  wrReq
);

    logic readBusy;   // request sent, data not back yet
    logic inReset;

    always_ff @(posedge clk)
    begin
        inReset <= !rstN;
        if (!rstN)
            readBusy <= 1'b0;
        else if (rdReq.valid)
            readBusy <= 1'b1;
        else if (rdValid)
            readBusy <= 1'b0;
    end

    noReadWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        readBusy |-> !rdReq.valid)
        else $error("read request issued while a read is outstanding");

    noWriteWithoutReady: assert property (@(posedge clk) disable iff (!rstN)
        wrReq.valid |-> wrReady)
        else $error("write strobe while wrReady is low");

    finishHeld: assert property (@(posedge clk) disable iff (!rstN)
        (finish && start) |=> finish)
        else $error("finish dropped while start is still high");

    quietInReset: assert property (@(posedge clk)
        (!rstN && inReset) |-> (!rdReq.valid && !wrReq.valid && !finish))
        else $error("bus strobe or finish active during reset");

endmodule

bind convLayer convLayerProps props (
    .clk(clk),
    .rstN(rstN),
    .start(start),
    .finish(finish),
    .rdValid(rdValid),
    .wrReady(wrReady),
    .rdReq(rdReq),
    .wrReq(wrReq)
);

`default_nettype wire

// File: vlog.f
hdl/convPkg.sv
hdl/convCtrl.sv
hdl/windowAddrGen.sv
hdl/windowBuffer.sv
hdl/macUnit.sv
hdl/convLayer.sv
test/convLayer_props.sv
test/convLayerTb.sv
